//--- logic/alu.sv
`timescale 1ns/1ns

module alu import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN:0]   difference;
    logic            lt_unsigned;
    logic            lt_signed;
    logic [XLEN-1:0] sum;

    assign sum = i_a + i_b;

    // One subtractor for SUB and both compares; the extra top bit is the borrow
    assign difference  = {1'b0, i_a} - {1'b0, i_b};
    assign lt_unsigned = difference[XLEN];
    assign lt_signed   = (i_a[XLEN-1] != i_b[XLEN-1]) ? i_a[XLEN-1] : difference[XLEN-1];

    always_comb begin
        o_result = sum;
        unique case (i_op)
            ALU_ADD:  o_result = sum;
            ALU_SUB:  o_result = difference[XLEN-1:0];
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  o_result = i_a << i_b[SHAMT_W-1:0];
        endcase
    end

endmodule

//--- logic/completion_pipe.sv
`timescale 1ns/1ns

module completion_pipe import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            i_issue,
    input  func_unit_e      i_fu,
    input  reg_addr_t       i_rd,
    input  logic [XLEN-1:0] i_alu_result,
    input  logic            i_mul_valid,
    input  logic [XLEN-1:0] i_mul_data,
    ex_status_if.pipe       status,
    output logic            o_wb_valid,
    output reg_addr_t       o_wb_rd,
    output logic [XLEN-1:0] o_wb_data
);

    logic            ex1_pending_q, ex1_pending_d;
    func_unit_e      ex1_select_q, ex1_select_d;
    reg_addr_t       ex1_rd_q, ex1_rd_d;
    logic [XLEN-1:0] ex1_alu_q, ex1_alu_d;
    logic            ex1_data_valid;
    logic [XLEN-1:0] ex1_data;

    logic            ex2_pending_q, ex2_pending_d;
    func_unit_e      ex2_select_q, ex2_select_d;
    reg_addr_t       ex2_rd_q, ex2_rd_d;
    logic [XLEN-1:0] ex2_alu_q, ex2_alu_d;
    logic            ex2_data_valid;
    logic [XLEN-1:0] ex2_data;

    logic ex2_ready;

    assign ex2_ready = !ex2_pending_q || ex2_data_valid;

    // A multiplier result belongs to EX2 while EX2 still waits on it
    assign ex1_data_valid = (ex1_select_q == FU_ALU) || (i_mul_valid && ex2_select_q != FU_MUL);
    assign ex1_data       = (ex1_select_q == FU_ALU) ? ex1_alu_q : i_mul_data;
    assign ex2_data_valid = (ex2_select_q == FU_ALU) || i_mul_valid;
    assign ex2_data       = (ex2_select_q == FU_ALU) ? ex2_alu_q : i_mul_data;

    ///////////////////////////////////////////////////////////////////////
    // EX1 stage
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        ex1_pending_d = ex1_pending_q;
        ex1_select_d  = ex1_select_q;
        ex1_rd_d      = ex1_rd_q;
        ex1_alu_d     = ex1_alu_q;

        // Hold a finished result locally while EX2 is blocked
        if (ex1_data_valid) begin
            ex1_select_d = FU_ALU;
            ex1_alu_d    = ex1_data;
        end
        if (ex2_ready) ex1_pending_d = 1'b0;

        if (i_issue) begin
            ex1_pending_d = 1'b1;
            ex1_select_d  = i_fu;
            ex1_rd_d      = i_rd;
            ex1_alu_d     = i_alu_result;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // EX2 stage
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        ex2_pending_d = ex2_pending_q;
        ex2_select_d  = ex2_select_q;
        ex2_rd_d      = ex2_rd_q;
        ex2_alu_d     = ex2_alu_q;

        // Retire
        if (ex2_data_valid) begin
            ex2_pending_d = 1'b0;
            ex2_select_d  = FU_ALU;
        end

        // Promote from EX1, already resolved if its data is there
        if (ex1_pending_q && ex2_ready) begin
            ex2_pending_d = 1'b1;
            ex2_rd_d      = ex1_rd_q;
            ex2_select_d  = ex1_data_valid ? FU_ALU : ex1_select_q;
            ex2_alu_d     = ex1_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_pending_q <= 1'b0;
            ex1_select_q  <= FU_ALU;
            ex1_rd_q      <= '0;
            ex2_pending_q <= 1'b0;
            ex2_select_q  <= FU_ALU;
            ex2_rd_q      <= '0;
        end else begin
            ex1_pending_q <= ex1_pending_d;
            ex1_select_q  <= ex1_select_d;
            ex1_rd_q      <= ex1_rd_d;
            ex2_pending_q <= ex2_pending_d;
            ex2_select_q  <= ex2_select_d;
            ex2_rd_q      <= ex2_rd_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ex1_alu_q <= ex1_alu_d;
        ex2_alu_q <= ex2_alu_d;
    end

    // Status for bypass and hazard checks
    assign status.ex1_pending    = ex1_pending_q;
    assign status.ex1_rd         = ex1_rd_q;
    assign status.ex1_data_valid = ex1_data_valid;
    assign status.ex1_data       = ex1_data;
    assign status.ex1_ready      = ex2_ready || !ex1_pending_q;
    assign status.ex2_pending    = ex2_pending_q;
    assign status.ex2_rd         = ex2_rd_q;
    assign status.ex2_data_valid = ex2_data_valid;
    assign status.ex2_data       = ex2_data;

    assign o_wb_valid = ex2_pending_q && ex2_data_valid;
    assign o_wb_rd    = ex2_rd_q;
    assign o_wb_data  = ex2_data;

endmodule

//--- logic/ex_status_if.sv
`timescale 1ns/1ns

interface ex_status_if import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) ();

    // EX1 stage
    logic            ex1_pending;
    reg_addr_t       ex1_rd;
    logic            ex1_data_valid;
    logic [XLEN-1:0] ex1_data;
    logic            ex1_ready;

    // EX2 stage
    logic            ex2_pending;
    reg_addr_t       ex2_rd;
    logic            ex2_data_valid;
    logic [XLEN-1:0] ex2_data;

    modport pipe (
        output ex1_pending, ex1_rd, ex1_data_valid, ex1_data, ex1_ready,
        output ex2_pending, ex2_rd, ex2_data_valid, ex2_data
    );

    modport hazard (
        input ex1_pending, ex1_rd, ex1_data_valid, ex1_data, ex1_ready,
        input ex2_pending, ex2_rd, ex2_data_valid, ex2_data
    );

endinterface

//--- logic/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic               i_valid,
    input  decoded_instr_t     i_instr,
    input  logic [XLEN-1:0]    i_rs1_val,
    input  logic [XLEN-1:0]    i_rs2_val,
    input  logic               i_mul_ready,
    ex_status_if.hazard        status,
    output logic               o_ex_ready,
    output logic               o_issue,
    output logic [XLEN-1:0]    o_rs1,
    output logic [XLEN-1:0]    o_rs2,
    output logic [XLEN-1:0]    o_operand_b
);

    logic data_hazard;
    logic struct_hazard;

    function automatic logic hit(input logic pending, input reg_addr_t rd, input reg_addr_t rs);
        return pending && rd == rs && rs != '0;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Bypass and data hazard
    ///////////////////////////////////////////////////////////////////////

    // EX2 first, so a younger EX1 result overrides it
    always_comb begin
        data_hazard = 1'b0;

        o_rs1 = i_rs1_val;
        if (hit(status.ex2_pending, status.ex2_rd, i_instr.rs1)) begin
            if (status.ex2_data_valid) o_rs1 = status.ex2_data;
            else data_hazard = 1'b1;
        end
        if (hit(status.ex1_pending, status.ex1_rd, i_instr.rs1)) begin
            if (status.ex1_data_valid) o_rs1 = status.ex1_data;
            else data_hazard = 1'b1;
        end

        o_rs2 = i_rs2_val;
        if (hit(status.ex2_pending, status.ex2_rd, i_instr.rs2)) begin
            if (status.ex2_data_valid) o_rs2 = status.ex2_data;
            else data_hazard = 1'b1;
        end
        if (hit(status.ex1_pending, status.ex1_rd, i_instr.rs2)) begin
            if (status.ex1_data_valid) o_rs2 = status.ex1_data;
            else data_hazard = 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Structural hazard and issue
    ///////////////////////////////////////////////////////////////////////

    assign struct_hazard = !status.ex1_ready || (i_instr.fu == FU_MUL && !i_mul_ready);

    assign o_ex_ready = !data_hazard && !struct_hazard;
    assign o_issue    = i_valid && o_ex_ready;

    // Sign-extended immediate replaces rs2 for the ALU
    assign o_operand_b = i_instr.use_imm ?
                         {{(XLEN-IMM_W){i_instr.imm[IMM_W-1]}}, i_instr.imm} : o_rs2;

endmodule

//--- logic/mul_unit.sv
`timescale 1ns/1ns

module mul_unit import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            i_start,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic            o_ready,
    output logic            o_valid,
    output logic [XLEN-1:0] o_value
);

    localparam int CNT_W = $clog2(XLEN);

    logic             busy_q;
    logic             valid_q;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [XLEN-1:0]  acc_q;

    // One multiplier bit per cycle, XLEN steps after the start edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (i_start) begin
            busy_q  <= 1'b1;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (busy_q) begin
            if (cnt_q == CNT_W'(XLEN - 1)) begin
                busy_q  <= 1'b0;
                valid_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Only the low word is kept, so the shifted-out bits are dropped
    always_ff @(posedge clk_i) begin
        if (i_start) begin
            mcand_q  <= i_a;
            mplier_q <= i_b;
            acc_q    <= '0;
        end else if (busy_q) begin
            if (mplier_q[0]) acc_q <= acc_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign o_ready = !busy_q;
    assign o_valid = valid_q;
    assign o_value = acc_q;

endmodule

//--- logic/operand_stage.sv
`timescale 1ns/1ns

module operand_stage import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            i_valid,
    output logic            o_ready,
    input  decoded_instr_t  i_instr,
    output logic            o_valid,
    output decoded_instr_t  o_instr,
    output logic [XLEN-1:0] o_rs1_val,
    output logic [XLEN-1:0] o_rs2_val,
    input  logic            i_ex_ready,
    input  logic            i_wb_en,
    input  reg_addr_t       i_wb_rd,
    input  logic [XLEN-1:0] i_wb_data
);

    logic            valid_q;
    decoded_instr_t  instr_q;
    logic [XLEN-1:0] rf_a;
    logic [XLEN-1:0] rf_b;

    // Free when empty, or when the held instruction leaves this cycle
    assign o_ready = !valid_q || i_ex_ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (i_valid && o_ready) begin
            valid_q <= 1'b1;
        end else if (valid_q && i_ex_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (i_valid && o_ready) begin
            instr_q <= i_instr;
        end
    end

    reg_file #(
        .XLEN (XLEN)
    ) u_reg_file (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .i_ra_sel  (instr_q.rs1),
        .i_rb_sel  (instr_q.rs2),
        .o_ra_data (rf_a),
        .o_rb_data (rf_b),
        .i_w_en    (i_wb_en),
        .i_w_sel   (i_wb_rd),
        .i_w_data  (i_wb_data)
    );

    // Bypass a write-back that lands on the same edge
    assign o_rs1_val = (i_wb_en && i_wb_rd == instr_q.rs1 && instr_q.rs1 != '0) ?
                       i_wb_data : rf_a;
    assign o_rs2_val = (i_wb_en && i_wb_rd == instr_q.rs2 && instr_q.rs2 != '0) ?
                       i_wb_data : rf_b;

    assign o_valid = valid_q;
    assign o_instr = instr_q;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  reg_addr_t       i_ra_sel,
    input  reg_addr_t       i_rb_sel,
    output logic [XLEN-1:0] o_ra_data,
    output logic [XLEN-1:0] o_rb_data,
    input  logic            i_w_en,
    input  reg_addr_t       i_w_sel,
    input  logic [XLEN-1:0] i_w_data
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    // Entry 0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_w_en && i_w_sel != '0) begin
            regs_q[i_w_sel] <= i_w_data;
        end
    end

    assign o_ra_data = regs_q[i_ra_sel];
    assign o_rb_data = regs_q[i_rb_sel];

endmodule

//--- logic/rv_exec_pkg.sv
package rv_exec_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths
    ///////////////////////////////////////////////////////////////////////

    localparam int XLEN_DEF   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 12;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    ///////////////////////////////////////////////////////////////////////
    // Operation encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL
    } alu_op_e;

    // Unit whose result a pipe stage waits for
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

    // Decoded instruction, 32 bits wide
    typedef struct packed {
        func_unit_e       fu;
        alu_op_e          alu_op;
        reg_addr_t        rd;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        logic             use_imm;
        logic [IMM_W-1:0] imm;
    } decoded_instr_t;

endpackage

//--- logic/rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top import rv_exec_pkg::*; #(
    parameter int XLEN = XLEN_DEF
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    // Issue
    input  logic             i_valid,
    output logic             o_ready,
    input  func_unit_e       i_fu,
    input  alu_op_e          i_alu_op,
    input  reg_addr_t        i_rd,
    input  reg_addr_t        i_rs1,
    input  reg_addr_t        i_rs2,
    input  logic             i_use_imm,
    input  logic [IMM_W-1:0] i_imm,

    // Write-back
    output logic             o_wb_valid,
    output reg_addr_t        o_wb_rd,
    output logic [XLEN-1:0]  o_wb_data
);

    decoded_instr_t  in_instr;
    decoded_instr_t  op_instr;
    logic            op_valid;
    logic            ex_ready;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            issue;
    logic [XLEN-1:0] ex_rs1;
    logic [XLEN-1:0] ex_rs2;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            mul_start;
    logic            mul_ready;
    logic            mul_valid;
    logic [XLEN-1:0] mul_data;

    ex_status_if #(.XLEN(XLEN)) ex_status ();

    assign in_instr = '{
        fu:      i_fu,
        alu_op:  i_alu_op,
        rd:      i_rd,
        rs1:     i_rs1,
        rs2:     i_rs2,
        use_imm: i_use_imm,
        imm:     i_imm
    };

    assign mul_start = issue && op_instr.fu == FU_MUL;

    operand_stage #(.XLEN(XLEN)) u_operand_stage (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_instr    (in_instr),
        .o_valid    (op_valid),
        .o_instr    (op_instr),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .i_ex_ready (ex_ready),
        .i_wb_en    (o_wb_valid),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data)
    );

    hazard_unit #(.XLEN(XLEN)) u_hazard_unit (
        .i_valid     (op_valid),
        .i_instr     (op_instr),
        .i_rs1_val   (rs1_val),
        .i_rs2_val   (rs2_val),
        .i_mul_ready (mul_ready),
        .status      (ex_status.hazard),
        .o_ex_ready  (ex_ready),
        .o_issue     (issue),
        .o_rs1       (ex_rs1),
        .o_rs2       (ex_rs2),
        .o_operand_b (operand_b)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .i_op     (op_instr.alu_op),
        .i_a      (ex_rs1),
        .i_b      (operand_b),
        .o_result (alu_result)
    );

    mul_unit #(.XLEN(XLEN)) u_mul_unit (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .i_start (mul_start),
        .i_a     (ex_rs1),
        .i_b     (ex_rs2),
        .o_ready (mul_ready),
        .o_valid (mul_valid),
        .o_value (mul_data)
    );

    completion_pipe #(.XLEN(XLEN)) u_completion_pipe (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .i_issue      (issue),
        .i_fu         (op_instr.fu),
        .i_rd         (op_instr.rd),
        .i_alu_result (alu_result),
        .i_mul_valid  (mul_valid),
        .i_mul_data   (mul_data),
        .status       (ex_status.pipe),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

endmodule

//--- rv_exec.f
logic/rv_exec_pkg.sv
logic/ex_status_if.sv
logic/reg_file.sv
logic/operand_stage.sv
logic/hazard_unit.sv
logic/alu.sv
logic/mul_unit.sv
logic/completion_pipe.sv
logic/rv_exec_top.sv
verif/tb_rv_exec.sv

//--- verif/tb_rv_exec.sv
`timescale 1ns/1ns

module tb_rv_exec import rv_exec_pkg::*;;

    localparam int XLEN           = 32;
    localparam int NUM_INSTR      = 400;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (XLEN + 4) + RESET_CYCLES;

    logic             clk_i;
    logic             rst_ni;
    logic             i_valid;
    logic             o_ready;
    func_unit_e       i_fu;
    alu_op_e          i_alu_op;
    reg_addr_t        i_rd;
    reg_addr_t        i_rs1;
    reg_addr_t        i_rs2;
    logic             i_use_imm;
    logic [IMM_W-1:0] i_imm;
    logic             o_wb_valid;
    reg_addr_t        o_wb_rd;
    logic [XLEN-1:0]  o_wb_data;

    logic [31:0]      lcg_state;
    logic [XLEN-1:0]  model_regs [NUM_REGS];
    reg_addr_t        exp_rd_q [$];
    logic [XLEN-1:0]  exp_data_q [$];
    int               sent;
    int               retired;
    int               cycle_count;
    logic             accepted;

    rv_exec_top #(.XLEN(XLEN)) DUT (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_fu       (i_fu),
        .i_alu_op   (i_alu_op),
        .i_rd       (i_rd),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .i_use_imm  (i_use_imm),
        .i_imm      (i_imm),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reference results straight from the ISA meaning of each operation
    function automatic logic [XLEN-1:0] model_result(input func_unit_e fu, input alu_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] product;
        product = a * b;
        if (fu == FU_MUL) return product[XLEN-1:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            ALU_SLTU: return (a < b) ? XLEN'(1) : XLEN'(0);
            default:  return a << b[$clog2(XLEN)-1:0];
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: write-back %0d has rd x%0d, expected x%0d",
                     $time, retired, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: write-back %0d has data %h, expected %h",
                     $time, retired, got, exp);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and model
    //////////////////////////////////////////////////////////////////////

    // New instruction or an idle cycle, x0..x7 only to keep dependencies dense
    task automatic drive_next();
        logic [31:0] r_idle;
        logic [31:0] r_op;
        logic [31:0] r_imm;
        logic        is_mul;
        r_idle = lcg_next();
        r_op   = lcg_next();
        r_imm  = lcg_next();
        is_mul = (r_op[31:16] % 5) == 0;
        if (sent >= NUM_INSTR || r_idle[17:16] == 2'b00) begin
            i_valid <= 1'b0;
        end else begin
            i_valid   <= 1'b1;
            i_fu      <= is_mul ? FU_MUL : FU_ALU;
            i_alu_op  <= alu_op_e'(r_op[20:18]);
            i_rd      <= reg_addr_t'(r_op[23:21]);
            i_rs1     <= reg_addr_t'(r_op[26:24]);
            i_rs2     <= reg_addr_t'(r_op[29:27]);
            // The multiplier always takes rs2
            i_use_imm <= is_mul ? 1'b0 : r_op[30];
            i_imm     <= r_imm[27:16];
        end
    endtask

    task automatic model_accept();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] result;
        a = model_regs[i_rs1];
        b = model_regs[i_rs2];
        if (i_fu == FU_ALU && i_use_imm) begin
            b = {{(XLEN-IMM_W){i_imm[IMM_W-1]}}, i_imm};
        end
        result = model_result(i_fu, i_alu_op, a, b);
        if (i_rd != '0) model_regs[i_rd] = result;
        exp_rd_q.push_back(i_rd);
        exp_data_q.push_back(result);
        sent++;
    endtask

    task automatic check_write_back();
        reg_addr_t       exp_rd;
        logic [XLEN-1:0] exp_data;
        if (o_wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("write-back of x%0d at %0t ns with no instruction outstanding",
                         o_wb_rd, $time);
                stop_with_failure();
            end
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_rd(o_wb_rd, exp_rd);
            check_data(o_wb_data, exp_data);
            retired++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lcg_state = 32'd9;
        sent      = 0;
        retired   = 0;
        accepted  = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        rst_ni    = 1'b0;
        i_valid   = 1'b0;
        i_fu      = FU_ALU;
        i_alu_op  = ALU_ADD;
        i_rd      = '0;
        i_rs1     = '0;
        i_rs2     = '0;
        i_use_imm = 1'b0;
        i_imm     = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_flag(o_wb_valid, 1'b0, "o_wb_valid after reset");
        check_flag(o_ready, 1'b1, "o_ready after reset");

        // Drive on the rising edge, sample at the falling edge
        while (retired < NUM_INSTR) begin
            @(posedge clk_i);
            if (!i_valid || accepted) drive_next();
            @(negedge clk_i);
            check_write_back();
            accepted = i_valid && o_ready;
            if (accepted) model_accept();
        end

        // Nothing may retire twice
        repeat (XLEN + 4) begin
            @(negedge clk_i);
            if (o_wb_valid) begin
                $display("extra write-back of x%0d at %0t ns after all instructions retired",
                         o_wb_rd, $time);
                stop_with_failure();
            end
        end

        $display("TEST PASSED");
        $finish;
    end

    // Limit covers a full multiply for every instruction
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: instructions did not retire within %0d cycles, %0d of %0d",
                         TIMEOUT_CYCLES, retired, NUM_INSTR);
                stop_with_failure();
            end
        end
    end

endmodule
